/* verilog/pipeline_pkg.sv */
// ####################################################################
// // Shared widths and command codes of the rendering front end.
// // Coordinates are 8 bits unsigned, so a buffer is at most 256 x 256.
// ####################################################################
package pipeline_pkg;

    // ################################################################
    // widths that carry a meaning.
    // ################################################################

    typedef logic [7:0] byte_t;  // one command or status byte.
    typedef logic [7:0] coord_t; // screen coordinate in pixels.
    typedef logic [7:0] color_t; // color index of a pixel.

    // The edge function is a difference of two products of coordinate
    // differences, so 18 signed bits hold every value inside the box.
    typedef logic signed [17:0] edge_t;

    // ################################################################
    // command stream encoding.
    // ################################################################

    // set the drawing color, one operand byte follows.
    localparam byte_t op_set_color = 8'h01;

    // draw a triangle, operands are x0 y0 x1 y1 x2 y2.
    localparam byte_t op_triangle = 8'h02;

    // no operands, answers with its own opcode.
    localparam byte_t op_ping = 8'h03;

    // Known commands reply with their own opcode.
    // Anything else is answered with this code.
    localparam byte_t st_error = 8'hEE;

    // number of operand bytes of a triangle command.
    localparam int tri_operands = 6;

endpackage

/* verilog/pipeline_head.sv */
// ####################################################################
// // Command head. One status byte answers every command.
// // Input stalls while a triangle or a status byte waits to leave.
// ####################################################################
`timescale 1ns/100ps

module pipeline_head (
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 cmd_in_valid,
    output logic                 cmd_in_ready,
    input  pipeline_pkg::byte_t  cmd_in_data,

    output logic                 cmd_out_valid,
    input  logic                 cmd_out_ready,
    output pipeline_pkg::byte_t  cmd_out_data,

    output logic                 tri_valid,
    input  logic                 tri_ready,
    output pipeline_pkg::coord_t tri_x0,
    output pipeline_pkg::coord_t tri_y0,
    output pipeline_pkg::coord_t tri_x1,
    output pipeline_pkg::coord_t tri_y1,
    output pipeline_pkg::coord_t tri_x2,
    output pipeline_pkg::coord_t tri_y2,
    output pipeline_pkg::color_t tri_color,

    output logic [3:0]           led
);
    import pipeline_pkg::*;

    typedef enum logic [2:0] {
        H_OPCODE,   // waiting for a command byte.
        H_COLOR,    // waiting for the color operand.
        H_OPERAND,  // collecting the six triangle coordinates.
        H_TRIANGLE, // triangle offered to the rasterizer.
        H_STATUS    // status byte offered on the output.
    } head_state_t;

    head_state_t state;
    coord_t      operand_q [tri_operands];
    logic [2:0]  operand_cnt;
    color_t      color_q;
    byte_t       status_q;
    logic [3:0]  tri_count;
    logic        in_fire;

    assign cmd_in_ready = (state == H_OPCODE) || (state == H_COLOR) || (state == H_OPERAND);
    assign in_fire      = cmd_in_valid && cmd_in_ready;

    assign cmd_out_valid = (state == H_STATUS);
    assign cmd_out_data  = status_q;

    assign tri_valid = (state == H_TRIANGLE);
    assign tri_x0    = operand_q[0];
    assign tri_y0    = operand_q[1];
    assign tri_x1    = operand_q[2];
    assign tri_y1    = operand_q[3];
    assign tri_x2    = operand_q[4];
    assign tri_y2    = operand_q[5];
    assign tri_color = color_q; // stable while the triangle waits, input is stalled.

    assign led = tri_count;

    // ################################################################
    // command parser
    // ################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= H_OPCODE;
            operand_cnt <= '0;
            color_q     <= '0;
            tri_count   <= '0;
        end else begin
            case (state)
                H_OPCODE: begin
                    if (in_fire) begin
                        operand_cnt <= '0;
                        case (cmd_in_data)
                            op_set_color: state <= H_COLOR;
                            op_triangle:  state <= H_OPERAND;
                            default:      state <= H_STATUS; // ping and unknown codes.
                        endcase
                    end
                end
                H_COLOR: begin
                    if (in_fire) begin
                        color_q <= cmd_in_data;
                        state   <= H_STATUS;
                    end
                end
                H_OPERAND: begin
                    if (in_fire) begin
                        if (operand_cnt == 3'(tri_operands - 1)) begin
                            state <= H_TRIANGLE;
                        end else begin
                            operand_cnt <= operand_cnt + 3'd1;
                        end
                    end
                end
                H_TRIANGLE: begin
                    if (tri_ready) begin
                        tri_count <= tri_count + 4'd1; // wraps, led shows the low bits.
                        state     <= H_STATUS;
                    end
                end
                H_STATUS: begin
                    if (cmd_out_ready) state <= H_OPCODE;
                end
                default: state <= H_OPCODE;
            endcase
        end
    end

    // operand and status payload.
    always_ff @(posedge clk) begin
        if (state == H_OPERAND && in_fire) begin
            operand_q[operand_cnt] <= cmd_in_data;
        end
        if (state == H_OPCODE && in_fire) begin
            case (cmd_in_data)
                op_ping, op_set_color, op_triangle: status_q <= cmd_in_data; // sent once the command ends.
                default: status_q <= st_error;
            endcase
        end
    end

    // ################################################################
    // handshake checks
    // ################################################################

    tri_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
        tri_valid && !tri_ready |=> tri_valid && $stable({tri_x0, tri_y0, tri_x1, tri_y1,
                                                          tri_x2, tri_y2, tri_color}))
        else $error("triangle changed before the rasterizer took it.");

    status_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
        cmd_out_valid && !cmd_out_ready |=> cmd_out_valid && $stable(cmd_out_data))
        else $error("status byte changed before it was taken.");

endmodule

/* verilog/pipeline_raster.sv */
// ####################################################################
// // Bounding box rasterizer. One box point is tested per cycle.
// // Either winding is drawn and zero area triangles draw nothing.
// ####################################################################
`timescale 1ns/100ps

module pipeline_raster #(
    parameter int BUFFER_WIDTH  = 160,
    parameter int BUFFER_HEIGHT = 120
) (
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 tri_valid,
    output logic                 tri_ready,
    input  pipeline_pkg::coord_t tri_x0,
    input  pipeline_pkg::coord_t tri_y0,
    input  pipeline_pkg::coord_t tri_x1,
    input  pipeline_pkg::coord_t tri_y1,
    input  pipeline_pkg::coord_t tri_x2,
    input  pipeline_pkg::coord_t tri_y2,
    input  pipeline_pkg::color_t tri_color,

    output logic                 pixel_m_valid,
    input  logic                 pixel_m_ready,
    output pipeline_pkg::color_t pixel_m_data,
    output pipeline_pkg::coord_t pixel_m_x,
    output pipeline_pkg::coord_t pixel_m_y,
    output logic                 pixel_m_last
);
    import pipeline_pkg::*;

    typedef enum logic [1:0] {R_IDLE, R_SCAN, R_FLUSH} raster_state_t;

    localparam coord_t x_limit = coord_t'(BUFFER_WIDTH - 1);
    localparam coord_t y_limit = coord_t'(BUFFER_HEIGHT - 1);

    function automatic edge_t diff(input coord_t a, input coord_t b);
        return edge_t'({10'b0, a}) - edge_t'({10'b0, b});
    endfunction

    // edge from (xa, ya) to (xb, yb), evaluated at (px, py).
    function automatic edge_t edge_at(input coord_t xa, input coord_t ya, input coord_t xb,
                                      input coord_t yb, input coord_t px, input coord_t py);
        return diff(px, xa) * diff(yb, ya) - diff(py, ya) * diff(xb, xa);
    endfunction

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    raster_state_t state;
    coord_t bx_min, by_min, bx_max, by_max, bx_raw, by_raw;
    edge_t  init_e [3], init_sx [3], init_sy [3];
    coord_t cur_x, cur_y, x_min, x_max, y_max, hold_x, hold_y;
    edge_t  e_q [3], row_q [3], step_x [3], step_y [3];
    color_t color_q;
    logic   hold_valid, covered, out_free, step, emit, row_end, skip;

    // ################################################################
    // setup at acceptance
    // ################################################################

    always_comb begin
        bx_min = min3(tri_x0, tri_x1, tri_x2);
        by_min = min3(tri_y0, tri_y1, tri_y2);
        bx_raw = max3(tri_x0, tri_x1, tri_x2);
        by_raw = max3(tri_y0, tri_y1, tri_y2);
        bx_max = (bx_raw > x_limit) ? x_limit : bx_raw; // clip to the buffer.
        by_max = (by_raw > y_limit) ? y_limit : by_raw;
        init_e[0]  = edge_at(tri_x0, tri_y0, tri_x1, tri_y1, bx_min, by_min);
        init_e[1]  = edge_at(tri_x1, tri_y1, tri_x2, tri_y2, bx_min, by_min);
        init_e[2]  = edge_at(tri_x2, tri_y2, tri_x0, tri_y0, bx_min, by_min);
        init_sx[0] = diff(tri_y1, tri_y0);
        init_sx[1] = diff(tri_y2, tri_y1);
        init_sx[2] = diff(tri_y0, tri_y2);
        init_sy[0] = diff(tri_x0, tri_x1);
        init_sy[1] = diff(tri_x1, tri_x2);
        init_sy[2] = diff(tri_x2, tri_x0);
    end

    // nothing to draw when the box lies off the buffer or the area is zero.
    assign skip = (bx_min > x_limit) || (by_min > y_limit) ||
                  (edge_at(tri_x0, tri_y0, tri_x1, tri_y1, tri_x2, tri_y2) == '0);

    assign tri_ready = (state == R_IDLE);
    assign covered   = (e_q[0] >= 0 && e_q[1] >= 0 && e_q[2] >= 0) ||
                       (e_q[0] <= 0 && e_q[1] <= 0 && e_q[2] <= 0);
    assign out_free  = !pixel_m_valid || pixel_m_ready;
    assign row_end   = (cur_x == x_max);
    // a covered point waits only when the held pixel cannot move out.
    assign step = (state == R_SCAN) && !(covered && hold_valid && !out_free);
    assign emit = hold_valid && out_free && ((state == R_SCAN && covered) || state == R_FLUSH);

    // ################################################################
    // scan control
    // ################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= R_IDLE;
            hold_valid    <= 1'b0;
            pixel_m_valid <= 1'b0;
        end else begin
            if (emit) pixel_m_valid <= 1'b1;
            else if (pixel_m_ready) pixel_m_valid <= 1'b0;
            case (state)
                R_IDLE: if (tri_valid && !skip) state <= R_SCAN;
                R_SCAN: begin
                    if (step && covered) hold_valid <= 1'b1;
                    if (step && row_end && cur_y == y_max) state <= R_FLUSH;
                end
                R_FLUSH: begin
                    if (!hold_valid || emit) begin // last pixel leaves with its flag.
                        hold_valid <= 1'b0;
                        state      <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == R_IDLE && tri_valid) begin
            cur_x   <= bx_min;
            cur_y   <= by_min;
            x_min   <= bx_min;
            x_max   <= bx_max;
            y_max   <= by_max;
            color_q <= tri_color;
            for (int i = 0; i < 3; i++) begin
                e_q[i]    <= init_e[i];
                row_q[i]  <= init_e[i];
                step_x[i] <= init_sx[i];
                step_y[i] <= init_sy[i];
            end
        end else if (step) begin
            if (row_end) begin
                cur_x <= x_min;
                cur_y <= cur_y + 8'd1;
                for (int i = 0; i < 3; i++) begin
                    row_q[i] <= row_q[i] + step_y[i];
                    e_q[i]   <= row_q[i] + step_y[i];
                end
            end else begin
                cur_x <= cur_x + 8'd1;
                for (int i = 0; i < 3; i++) e_q[i] <= e_q[i] + step_x[i];
            end
        end
        if (step && covered) begin
            hold_x <= cur_x;
            hold_y <= cur_y;
        end
        if (emit) begin
            pixel_m_x    <= hold_x;
            pixel_m_y    <= hold_y;
            pixel_m_data <= color_q;
            pixel_m_last <= (state == R_FLUSH);
        end
    end

    out_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
        pixel_m_valid && !pixel_m_ready |=> pixel_m_valid &&
            $stable({pixel_m_x, pixel_m_y, pixel_m_data, pixel_m_last}))
        else $error("pixel beat changed under back-pressure.");

    in_buffer_a: assert property (@(posedge clk) disable iff (!arst_n)
        pixel_m_valid |-> (pixel_m_x <= x_limit) && (pixel_m_y <= y_limit))
        else $error("pixel lies outside the buffer.");

endmodule

/* verilog/pipeline.sv */
// ####################################################################
// // Front of the render pipeline. Head feeds the rasterizer.
// // Framebuffer and display output are not part of this block.
// ####################################################################
`timescale 1ns/100ps

module pipeline #(
    parameter int BUFFER_WIDTH  = 160,
    parameter int BUFFER_HEIGHT = 120
) (
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 cmd_in_valid,
    output logic                 cmd_in_ready,
    input  pipeline_pkg::byte_t  cmd_in_data,

    output logic                 cmd_out_valid,
    input  logic                 cmd_out_ready,
    output pipeline_pkg::byte_t  cmd_out_data,

    output logic                 pixel_m_valid,
    input  logic                 pixel_m_ready,
    output pipeline_pkg::color_t pixel_m_data,
    output pipeline_pkg::coord_t pixel_m_x,
    output pipeline_pkg::coord_t pixel_m_y,
    output logic                 pixel_m_last,

    output logic [3:0]           led
);
    import pipeline_pkg::*;

    // triangle channel from head to rasterizer.
    wire logic   tri_valid;
    wire logic   tri_ready;
    wire coord_t tri_x0, tri_y0, tri_x1, tri_y1, tri_x2, tri_y2;
    wire color_t tri_color;

    pipeline_head pipeline_head_inst (
        .clk(clk),
        .arst_n(arst_n),
        .cmd_in_valid(cmd_in_valid),
        .cmd_in_ready(cmd_in_ready),
        .cmd_in_data(cmd_in_data),
        .cmd_out_valid(cmd_out_valid),
        .cmd_out_ready(cmd_out_ready),
        .cmd_out_data(cmd_out_data),
        .tri_valid(tri_valid),
        .tri_ready(tri_ready),
        .tri_x0(tri_x0), .tri_y0(tri_y0),
        .tri_x1(tri_x1), .tri_y1(tri_y1),
        .tri_x2(tri_x2), .tri_y2(tri_y2),
        .tri_color(tri_color),
        .led(led)
    );

    pipeline_raster #(
        .BUFFER_WIDTH(BUFFER_WIDTH),
        .BUFFER_HEIGHT(BUFFER_HEIGHT)
    ) pipeline_raster_inst (
        .clk(clk),
        .arst_n(arst_n),
        .tri_valid(tri_valid),
        .tri_ready(tri_ready),
        .tri_x0(tri_x0), .tri_y0(tri_y0),
        .tri_x1(tri_x1), .tri_y1(tri_y1),
        .tri_x2(tri_x2), .tri_y2(tri_y2),
        .tri_color(tri_color),
        .pixel_m_valid(pixel_m_valid), // pixels leave the block directly.
        .pixel_m_ready(pixel_m_ready),
        .pixel_m_data(pixel_m_data),
        .pixel_m_x(pixel_m_x),
        .pixel_m_y(pixel_m_y),
        .pixel_m_last(pixel_m_last)
    );

endmodule

/* verification/pipeline_tb.sv */
// ####################################################################
// Testbench for the render front end with a 32 x 24 buffer.
// Commands come from verification/pipeline_patterns.txt, read from the
// project root. The file is run twice, first with both outputs always
// ready, then with random back-pressure on both outputs.
// ####################################################################
`timescale 1ns/100ps

module pipeline_tb;
    import pipeline_pkg::*;

    localparam int buf_w      = 32;
    localparam int buf_h      = 24;
    localparam int wait_limit = 5000; // cycles, enough for a full box scan under stalls.

    logic        clk, arst_n;
    logic        cmd_in_valid, cmd_in_ready, cmd_out_valid, cmd_out_ready;
    byte_t       cmd_in_data, cmd_out_data;
    logic        pixel_m_valid, pixel_m_ready, pixel_m_last;
    color_t      pixel_m_data;
    coord_t      pixel_m_x, pixel_m_y;
    logic [3:0]  led;

    int          cmd_len [$];
    byte_t       cmd_bytes [$], cmd_status [$], exp_stat [$], rec_stat [$];
    logic [24:0] exp_pix [$], rec_pix [$]; // {last, x, y, color}.
    color_t      model_color;
    int          tri_total, pass_no, pix_idx, stat_idx;
    int          value_errors, flow_errors, timeout_errors;
    logic        random_bp;
    logic [31:0] rng;

    pipeline #(.BUFFER_WIDTH(buf_w), .BUFFER_HEIGHT(buf_h)) pipeline_inst (
        .clk(clk), .arst_n(arst_n),
        .cmd_in_valid(cmd_in_valid), .cmd_in_ready(cmd_in_ready), .cmd_in_data(cmd_in_data),
        .cmd_out_valid(cmd_out_valid), .cmd_out_ready(cmd_out_ready),
        .cmd_out_data(cmd_out_data),
        .pixel_m_valid(pixel_m_valid), .pixel_m_ready(pixel_m_ready),
        .pixel_m_data(pixel_m_data), .pixel_m_x(pixel_m_x), .pixel_m_y(pixel_m_y),
        .pixel_m_last(pixel_m_last), .led(led)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ################################################################
    // helpers and the reference rasterizer
    // ################################################################

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    function automatic int smallest(input int a, input int b, input int c);
        return (a < b) ? ((a < c) ? a : c) : ((b < c) ? b : c);
    endfunction

    function automatic int largest(input int a, input int b, input int c);
        return (a > b) ? ((a > c) ? a : c) : ((b > c) ? b : c);
    endfunction

    // signed side of point (px, py) against the edge from (xa, ya) to (xb, yb).
    function automatic int edge_value(input int xa, input int ya, input int xb, input int yb,
                                      input int px, input int py);
        return (px - xa) * (yb - ya) - (py - ya) * (xb - xa);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            value_errors++;
            $display("** Error at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, got, want);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d value, %0d flow, %0d timeout",
                 value_errors, flow_errors, timeout_errors);
    endtask

    task automatic report_timeout(input string what);
        timeout_errors++;
        $display("gave up waiting for %s after %0d cycles.", what, wait_limit);
    endtask

    // expected beats of one triangle, scanned by rows over the clipped box.
    task automatic add_triangle(input int x0, input int y0, input int x1, input int y1,
                                input int x2, input int y2);
        logic [24:0] found [$];
        logic [24:0] tail;
        int e0, e1, e2, x_lo, x_hi, y_lo, y_hi;
        x_lo = smallest(x0, x1, x2);
        y_lo = smallest(y0, y1, y2);
        x_hi = (largest(x0, x1, x2) < buf_w) ? largest(x0, x1, x2) : buf_w - 1;
        y_hi = (largest(y0, y1, y2) < buf_h) ? largest(y0, y1, y2) : buf_h - 1;
        if (edge_value(x0, y0, x1, y1, x2, y2) != 0) begin // zero area draws nothing.
            for (int y = y_lo; y <= y_hi; y++) begin
                for (int x = x_lo; x <= x_hi; x++) begin
                    e0 = edge_value(x0, y0, x1, y1, x, y);
                    e1 = edge_value(x1, y1, x2, y2, x, y);
                    e2 = edge_value(x2, y2, x0, y0, x, y);
                    if ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0))
                        found.push_back({1'b0, x[7:0], y[7:0], model_color});
                end
            end
        end
        if (found.size() != 0) begin
            tail = found.pop_back();
            found.push_back({1'b1, tail[23:0]}); // flag on the final covered point.
        end
        foreach (found[i]) exp_pix.push_back(found[i]);
    endtask

    // ################################################################
    // stimulus
    // ################################################################

    task automatic load_patterns();
        int    fd, n, r;
        byte_t b;
        string line;
        fd = $fopen("verification/pipeline_patterns.txt", "r");
        if (fd == 0) begin
            flow_errors++;
            $display("the pattern file could not be opened.");
        end else begin
            r = $fgets(line, fd); // two lines of column notes.
            r = $fgets(line, fd);
            while ($fscanf(fd, "%d", n) == 1) begin
                for (int k = 0; k < n; k++) begin
                    r = $fscanf(fd, "%h", b);
                    cmd_bytes.push_back(b);
                end
                r = $fscanf(fd, "%h", b);
                cmd_status.push_back(b);
                cmd_len.push_back(n);
            end
            $fclose(fd);
            if (cmd_len.size() == 0) begin
                flow_errors++;
                $display("the pattern file holds no commands.");
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #10;
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        arst_n      = 1'b1;
        model_color = '0;
        tri_total   = 0;
        pix_idx     = 0;
        stat_idx    = 0;
        check_value("cmd_in_ready", cmd_in_ready, 1);
        check_value("cmd_out_valid", cmd_out_valid, 0);
        check_value("pixel_m_valid", pixel_m_valid, 0);
        check_value("led", led, 0);
    endtask

    // called 10 ns after a rising edge and returns at the same phase.
    task automatic send_byte(input byte_t b);
        int t;
        t            = 0;
        cmd_in_valid = 1'b1;
        cmd_in_data  = b;
        @(negedge clk);
        while (!cmd_in_ready && t < wait_limit) begin
            @(negedge clk);
            t++;
        end
        if (!cmd_in_ready) report_timeout("cmd_in_ready");
        else begin
            @(posedge clk);
            #10;
        end
        cmd_in_valid = 1'b0;
    endtask

    task automatic run_patterns();
        int pos;
        pos = 0;
        for (int c = 0; c < cmd_len.size() && timeout_errors == 0; c++) begin
            if (cmd_bytes[pos] == op_set_color && cmd_len[c] == 2) begin
                model_color = cmd_bytes[pos + 1];
            end else if (cmd_bytes[pos] == op_triangle && cmd_len[c] == 7) begin
                add_triangle(cmd_bytes[pos + 1], cmd_bytes[pos + 2], cmd_bytes[pos + 3],
                             cmd_bytes[pos + 4], cmd_bytes[pos + 5], cmd_bytes[pos + 6]);
                tri_total++;
            end
            exp_stat.push_back(cmd_status[c]);
            for (int k = 0; k < cmd_len[c] && timeout_errors == 0; k++)
                send_byte(cmd_bytes[pos + k]);
            pos += cmd_len[c];
        end
    endtask

    task automatic drain_outputs();
        int t;
        t = 0;
        while ((exp_pix.size() != 0 || exp_stat.size() != 0) && t < wait_limit) begin
            @(posedge clk);
            t++;
        end
        if (exp_pix.size() != 0 || exp_stat.size() != 0) report_timeout("the expected beats");
        else repeat (20) @(posedge clk); // room for a stray beat to show up.
    endtask

    // readies change 10 ns after the edge, so they are steady at the falling edge.
    always @(posedge clk) begin
        #10;
        if (random_bp) begin
            rng           = next_random(rng);
            pixel_m_ready = rng[0];
            cmd_out_ready = rng[7];
        end else begin
            pixel_m_ready = 1'b1;
            cmd_out_ready = 1'b1;
        end
    end

    // ################################################################
    // output monitors, sampled at the falling edge before the transfer
    // ################################################################

    always @(negedge clk) begin : pixel_monitor
        logic [24:0] got, want;
        if (arst_n && pixel_m_valid && pixel_m_ready) begin
            got = {pixel_m_last, pixel_m_x, pixel_m_y, pixel_m_data};
            assert (exp_pix.size() != 0) else begin
                flow_errors++;
                $display("an unexpected pixel beat was sent at %0d ns.", $time);
            end
            if (exp_pix.size() != 0) begin
                want = exp_pix.pop_front();
                check_value("pixel_m_x", pixel_m_x, want[23:16]);
                check_value("pixel_m_y", pixel_m_y, want[15:8]);
                check_value("pixel_m_data", pixel_m_data, want[7:0]);
                check_value("pixel_m_last", pixel_m_last, want[24]);
            end
            if (pass_no == 1) rec_pix.push_back(got);
            else if (pix_idx < rec_pix.size()) check_value("pixel beat", got, rec_pix[pix_idx]);
            pix_idx++;
        end
    end

    always @(negedge clk) begin : status_monitor
        if (arst_n && cmd_out_valid && cmd_out_ready) begin
            assert (exp_stat.size() != 0) else begin
                flow_errors++;
                $display("an unexpected status byte was sent at %0d ns.", $time);
            end
            if (exp_stat.size() != 0) check_value("cmd_out_data", cmd_out_data,
                                                  exp_stat.pop_front());
            if (pass_no == 1) rec_stat.push_back(cmd_out_data);
            else if (stat_idx < rec_stat.size()) check_value("cmd_out_data of the first run",
                                                             cmd_out_data, rec_stat[stat_idx]);
            stat_idx++;
        end
    end

    initial begin
        arst_n         = 1'b0;
        cmd_in_valid   = 1'b0;
        cmd_in_data    = '0;
        cmd_out_ready  = 1'b1;
        pixel_m_ready  = 1'b1;
        random_bp      = 1'b0;
        rng            = 32'd14343;
        pass_no        = 0;
        value_errors   = 0;
        flow_errors    = 0;
        timeout_errors = 0;
        load_patterns();
        for (int p = 1; p <= 2 && cmd_len.size() != 0 && timeout_errors == 0; p++) begin
            pass_no   = p;
            random_bp = (p == 2); // the second run stalls both outputs.
            apply_reset();
            run_patterns();
            if (timeout_errors == 0) drain_outputs();
            if (timeout_errors == 0) check_value("led", led, tri_total % 16);
        end
        print_counts();
        if (value_errors + flow_errors + timeout_errors == 0) $display("*** PASSED ***");
        else $display("*** FAILED ***");
        $finish;
    end

endmodule

/* verification/pipeline_patterns.txt */
// columns: byte count, then that many command bytes in hex, then the expected status in hex.
// the buffer is 32 x 24 and triangle operands are x0 y0 x1 y1 x2 y2.
1 03 03
1 7f ee
1 00 ee
2 01 05 01
7 02 02 02 0a 03 05 09 02
7 02 02 02 05 09 0a 03 02
1 03 03
2 01 2a 01
7 02 00 00 07 00 00 05 02
7 02 1c 14 28 10 18 1e 02
7 02 04 04 08 08 0c 0c 02
7 02 06 06 06 06 06 06 02
7 02 30 30 40 30 30 40 02
1 a5 ee
2 01 ff 01
7 02 0a 0a 0b 0a 0a 0b 02
7 02 00 00 1f 00 00 17 02
7 02 1f 17 00 17 1f 00 02
2 01 07 01
7 02 10 02 16 0c 0a 0c 02
7 02 0a 0c 16 0c 10 02 02
7 02 03 14 1e 15 05 02 02
7 02 14 05 14 05 14 05 02
1 03 03
2 01 80 01
7 02 00 10 40 14 08 30 02
7 02 1a 02 1e 06 1a 0a 02
7 02 05 05 09 05 07 08 02
1 fe ee
7 02 11 11 13 15 0f 15 02

/* list.f */
verilog/pipeline_pkg.sv
verilog/pipeline_head.sv
verilog/pipeline_raster.sv
verilog/pipeline.sv
verification/pipeline_tb.sv

/* Bender.yml */
package:
  name: pipeline

sources:
  - files:
      - verilog/pipeline_pkg.sv
      - verilog/pipeline_head.sv
      - verilog/pipeline_raster.sv
      - verilog/pipeline.sv
  - target: test
    files:
      - verification/pipeline_tb.sv
